// File: include/sram_config.svh
`ifndef SRAM_CONFIG_SVH
`define SRAM_CONFIG_SVH

// address bus width in bits
`define SRAM_ADDR_W 8

// data word width in bits
`define SRAM_DATA_W 16

// number of words, one per address
`define SRAM_DEPTH (1 << `SRAM_ADDR_W)

`endif

// File: src/sram_pkg.sv
`include "sram_config.svh"

package sram_pkg;

  // access sequencer states
  typedef enum logic [1:0] {
    IDLE  = 2'b00,  // waiting for a strobe, ready high
    READ  = 2'b01,  // array drives the bus
    WRITE = 2'b10,  // datapath drives the bus
    DONE  = 2'b11   // bus released, one turnaround cycle
  } state_t;

  // word address into the array
  typedef logic [`SRAM_ADDR_W-1:0] addr_t;

  // one data word on the shared bus
  typedef logic [`SRAM_DATA_W-1:0] data_t;

endpackage

// File: src/sram_fsm.sv
`timescale 1ns/100ps

module sram_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic read_req,       // one-cycle read strobe
  input  logic write_req,      // one-cycle write strobe

  output logic ready,          // high only in IDLE
  output logic latch_addr,     // held address onto the address bus
  output logic latch_data,     // held write data toward the bus
  output logic latch_read,     // capture the bus at the end of READ
  output logic drive_data_en,  // datapath owns the data bus

  output logic sram_ce_n,
  output logic sram_oe_n,
  output logic sram_we_n
);

  import sram_pkg::*;

  state_t current_state;
  state_t next_state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      current_state <= IDLE;
    end else begin
      current_state <= next_state;
    end
  end

  // one access per accepted strobe, fixed three-cycle turnaround
  always_comb begin
    next_state = current_state;
    unique case (current_state)
      IDLE: begin
        if (write_req) begin  // write wins over a same-cycle read
          next_state = WRITE;
        end else if (read_req) begin
          next_state = READ;
        end else begin
          next_state = IDLE;
        end
      end
      READ: begin
        next_state = DONE;
      end
      WRITE: begin
        next_state = DONE;
      end
      DONE: begin
        next_state = IDLE;  // ready comes back next cycle
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  // Moore decode, everything inactive unless the state asks for it
  always_comb begin
    ready         = 1'b0;
    latch_addr    = 1'b0;
    latch_data    = 1'b0;
    latch_read    = 1'b0;
    drive_data_en = 1'b0;
    sram_ce_n     = 1'b1;  // enables are active low
    sram_oe_n     = 1'b1;
    sram_we_n     = 1'b1;

    unique case (current_state)
      IDLE: begin
        ready = 1'b1;
      end
      READ: begin
        latch_addr = 1'b1;
        latch_read = 1'b1;  // datapath samples at the edge leaving READ
        sram_ce_n  = 1'b0;
        sram_oe_n  = 1'b0;
      end
      WRITE: begin
        latch_addr    = 1'b1;
        latch_data    = 1'b1;
        drive_data_en = 1'b1;
        sram_ce_n     = 1'b0;
        sram_we_n     = 1'b0;  // array stores at the edge leaving WRITE
      end
      DONE: begin
        // bus turnaround, nothing asserted
        ready = 1'b0;
      end
      default: begin
        ready = 1'b0;
      end
    endcase
  end

endmodule

// File: src/sram_datapath.sv
`timescale 1ns/100ps

module sram_datapath (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            ready,          // sequencer idle, requests may load
  input  logic            latch_addr,
  input  logic            latch_data,
  input  logic            latch_read,
  input  logic            drive_data_en,
  input  sram_pkg::addr_t req_addr,
  input  sram_pkg::data_t req_wdata,
  output sram_pkg::addr_t sram_addr,
  inout  sram_pkg::data_t sram_data,
  output sram_pkg::data_t rdata,
  output logic            rd_valid
);

  import sram_pkg::*;

  addr_t addr_q;      // request address held through the access
  data_t wdata_q;     // request write data held through the access
  data_t rdata_q;     // last word read from the array
  logic  rd_valid_q;
  logic  bus_drive;   // datapath owns sram_data this cycle

  // follow the client inputs while idle
  // the accepting cycle is the last load, so its values stay put
  always_ff @(posedge clk) begin
    if (ready) begin
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
  end

  // address bus parks at zero outside an access to limit toggling
  assign sram_addr = latch_addr ? addr_q : '0;

  assign bus_drive = latch_data && drive_data_en;

  // tri-state driver, released except during WRITE
  assign sram_data = bus_drive ? wdata_q : 'z;

  // capture the array output at the edge that ends READ
  always_ff @(posedge clk) begin
    if (latch_read) begin
      rdata_q <= sram_data;
    end
  end

  // valid is the capture enable one cycle late, so it lines up with DONE
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= latch_read;
    end
  end

  assign rdata    = rdata_q;   // holds until the next read
  assign rd_valid = rd_valid_q;

endmodule

// File: src/sram_array.sv
`timescale 1ns/100ps

`include "sram_config.svh"

module sram_array (
  input  logic            clk,
  input  logic            sram_ce_n,   // chip enable, active low
  input  logic            sram_oe_n,   // output enable, active low
  input  logic            sram_we_n,   // write enable, active low
  input  sram_pkg::addr_t sram_addr,
  inout  sram_pkg::data_t sram_data
);

  import sram_pkg::*;

  data_t mem [0:`SRAM_DEPTH-1];  // contents come up unknown
  logic  wr_en;
  logic  rd_en;

  assign wr_en = !sram_ce_n && !sram_we_n;
  assign rd_en = !sram_ce_n && !sram_oe_n && sram_we_n;  // write enable blocks output

  // synchronous write from whatever sits on the bus
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[sram_addr] <= sram_data;
    end
  end

  // asynchronous read, bus released whenever output is not enabled
  assign sram_data = rd_en ? mem[sram_addr] : 'z;

endmodule

// File: src/sram_subsys_top.sv
`timescale 1ns/100ps

module sram_subsys_top (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            read_req,
  input  logic            write_req,
  input  sram_pkg::addr_t req_addr,
  input  sram_pkg::data_t req_wdata,
  output logic            ready,
  output sram_pkg::data_t rdata,
  output logic            rd_valid
);

  import sram_pkg::*;

  // sequencer to datapath strobes
  logic latch_addr;
  logic latch_data;
  logic latch_read;
  logic drive_data_en;

  // SRAM control, address and shared data bus
  wire   sram_ce_n;
  wire   sram_oe_n;
  wire   sram_we_n;
  wire   addr_t sram_addr;
  wire   data_t sram_data;  // driven by datapath or array, never both

  sram_fsm u_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .read_req      (read_req),
    .write_req     (write_req),
    .ready         (ready),
    .latch_addr    (latch_addr),
    .latch_data    (latch_data),
    .latch_read    (latch_read),
    .drive_data_en (drive_data_en),
    .sram_ce_n     (sram_ce_n),
    .sram_oe_n     (sram_oe_n),
    .sram_we_n     (sram_we_n)
  );

  sram_datapath u_datapath (
    .clk           (clk),
    .rst_n         (rst_n),
    .ready         (ready),
    .latch_addr    (latch_addr),
    .latch_data    (latch_data),
    .latch_read    (latch_read),
    .drive_data_en (drive_data_en),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .sram_addr     (sram_addr),
    .sram_data     (sram_data),
    .rdata         (rdata),
    .rd_valid      (rd_valid)
  );

  sram_array u_array (
    .clk       (clk),
    .sram_ce_n (sram_ce_n),
    .sram_oe_n (sram_oe_n),
    .sram_we_n (sram_we_n),
    .sram_addr (sram_addr),
    .sram_data (sram_data)
  );

endmodule

// File: tests/sram_sva.sv
`timescale 1ns/100ps

module sram_sva (
  input logic             clk,
  input logic             rst_n,
  input sram_pkg::state_t current_state,
  input logic             ready,
  input logic             drive_data_en,
  input logic             sram_ce_n,
  input logic             sram_oe_n,
  input logic             sram_we_n
);

  import sram_pkg::*;

  // output and write enable never active together
  a_oe_we_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(!sram_oe_n && !sram_we_n))
    else $error("sram_oe_n and sram_we_n both low");

  a_drive_only_in_write: assert property (@(posedge clk) disable iff (!rst_n)
    drive_data_en |-> !sram_we_n)  // bus driven only while the array writes
    else $error("drive_data_en high while sram_we_n is high");

  a_ready_chip_idle: assert property (@(posedge clk) disable iff (!rst_n)
    ready |-> sram_ce_n)
    else $error("ready high while sram_ce_n is low");

  // every access ends in one turnaround cycle
  a_access_then_done: assert property (@(posedge clk) disable iff (!rst_n)
    (current_state == READ || current_state == WRITE) |=> current_state == DONE)
    else $error("READ or WRITE not followed by DONE");

endmodule

bind sram_fsm sram_sva u_sva (
  .clk           (clk),
  .rst_n         (rst_n),
  .current_state (current_state),
  .ready         (ready),
  .drive_data_en (drive_data_en),
  .sram_ce_n     (sram_ce_n),
  .sram_oe_n     (sram_oe_n),
  .sram_we_n     (sram_we_n)
);

// File: tests/sram_tb.sv
`timescale 1ns/100ps

`include "sram_config.svh"

module sram_tb;

  import sram_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 5;    // inputs move this long after the rising edge
  localparam int WAIT_LIMIT  = 20;   // cycles allowed for any single wait
  localparam int RANDOM_OPS  = 300;

  logic  clk;
  logic  rst_n;
  logic  read_req;
  logic  write_req;
  addr_t req_addr;
  data_t req_wdata;
  logic  ready;
  data_t rdata;
  logic  rd_valid;

  data_t ref_mem     [0:`SRAM_DEPTH-1];  // reference memory
  bit    ref_written [0:`SRAM_DEPTH-1];  // address holds a known word

  data_t exp_data_q[$];   // expected word per outstanding read
  addr_t exp_addr_q[$];
  bit    exp_skip_q[$];   // read of a never written address
  int    exp_cycle_q[$];  // cycle in which the read was accepted

  int          cycle = 0;
  int          data_errors = 0;
  int          timing_errors = 0;
  int          other_errors = 0;
  int unsigned seed_val;

  sram_subsys_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .read_req  (read_req),
    .write_req (write_req),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .ready     (ready),
    .rdata     (rdata),
    .rd_valid  (rd_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // expected read word for an address, from the reference memory
  function automatic data_t expected_word(addr_t a);
    return ref_mem[a];
  endfunction

  task automatic report_and_finish();
    $display("errors: data %0d, timing %0d, other %0d",
             data_errors, timing_errors, other_errors);
    if (data_errors + timing_errors + other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic abort_run(string why);
    other_errors++;
    $display("ERROR: %s at cycle %0d", why, cycle);
    report_and_finish();
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      data_errors++;
      $display("MISMATCH %s: got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cycle);
    end
  endtask

  // one request: wait for ready, strobe for one cycle, then wait out the access
  // with noise set, busy cycles carry strobes that must be dropped
  task automatic issue(input logic rd, input logic wr, input addr_t a, input data_t d,
                       input bit noise);
    int waited;
    int accept_cycle;
    waited = 0;
    while (ready !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
    end
    assert (ready === 1'b1) else abort_run("timed out waiting for ready before a request");
    read_req     = rd;
    write_req    = wr;
    req_addr     = a;
    req_wdata    = d;
    accept_cycle = cycle;
    if (wr) begin  // write wins over a same-cycle read
      ref_mem[a]     = d;
      ref_written[a] = 1'b1;
    end else if (rd) begin
      exp_data_q.push_back(expected_word(a));
      exp_addr_q.push_back(a);
      exp_skip_q.push_back(!ref_written[a]);
      exp_cycle_q.push_back(accept_cycle);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    read_req  = 1'b0;
    write_req = 1'b0;
    waited    = 0;
    while (ready !== 1'b1 && waited < WAIT_LIMIT) begin
      if (noise) begin
        write_req = (waited == 0);  // a write first, then a read
        read_req  = (waited != 0);
        req_addr  = ~a;
        req_wdata = ~d;
      end
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
    end
    read_req  = 1'b0;
    write_req = 1'b0;
    assert (ready === 1'b1) else abort_run("timed out waiting for ready after a request");
    assert (cycle - accept_cycle == 3) else begin
      timing_errors++;
      $display("ERROR: ready returned %0d cycles after acceptance instead of 3",
               cycle - accept_cycle);
    end
  endtask

  // compare process, samples at the falling edge where outputs are settled
  initial begin : compare_reads
    data_t exp_word;
    addr_t exp_addr;
    bit    skip;
    int    issued;
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && rd_valid !== 1'b0) begin
        assert (exp_data_q.size() > 0) else begin
          other_errors++;
          $display("ERROR: rd_valid high at cycle %0d with no read outstanding", cycle);
        end
        if (exp_data_q.size() > 0) begin
          exp_word = exp_data_q.pop_front();
          exp_addr = exp_addr_q.pop_front();
          skip     = exp_skip_q.pop_front();
          issued   = exp_cycle_q.pop_front();
          assert (cycle - issued == 2) else begin
            timing_errors++;
            $display("ERROR: rd_valid came %0d cycles after acceptance instead of 2",
                     cycle - issued);
          end
          if (!skip) begin
            check_value($sformatf("rdata[0x%h]", exp_addr), rdata, exp_word);
          end
        end
      end
    end
  end

  initial begin : stimulus
    int    waited;
    logic  rd;
    addr_t a;
    data_t d;
    addr_t last_addr;
    addr_t mid_addr;
    seed_val  = $urandom(48930);
    last_addr = addr_t'(`SRAM_DEPTH - 1);
    mid_addr  = addr_t'(`SRAM_DEPTH / 2);
    rst_n     = 1'b0;
    read_req  = 1'b0;
    write_req = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    // idle state straight out of reset
    check_value("ready", ready, 1);
    check_value("rd_valid", rd_valid, 0);
    repeat (4) @(posedge clk);  // any rd_valid here is flagged by the compare process
    #DRIVE_DELAY;

    // first, last and middle address
    issue(1'b0, 1'b1, '0, 16'ha5a5, 1'b0);
    issue(1'b0, 1'b1, last_addr, 16'h5a5a, 1'b0);
    issue(1'b0, 1'b1, mid_addr, 16'h1234, 1'b0);
    issue(1'b1, 1'b0, '0, '0, 1'b0);
    issue(1'b1, 1'b0, last_addr, '0, 1'b0);
    issue(1'b1, 1'b0, mid_addr, '0, 1'b0);

    // combined strobe performs the write only
    issue(1'b1, 1'b1, 8'h42, 16'hbeef, 1'b0);
    issue(1'b1, 1'b0, 8'h42, '0, 1'b0);

    // strobes during busy cycles target ~addr with ~data and must be dropped
    issue(1'b0, 1'b1, 8'h3c, 16'h0f0f, 1'b0);
    issue(1'b0, 1'b1, 8'hc3, 16'h7e81, 1'b0);
    issue(1'b0, 1'b1, 8'h3c, 16'hc0de, 1'b1);
    issue(1'b1, 1'b0, 8'h3c, '0, 1'b1);
    issue(1'b1, 1'b0, 8'hc3, '0, 1'b0);

    for (int i = 0; i < RANDOM_OPS; i++) begin
      rd = ($urandom % 2 == 0);
      a  = addr_t'($urandom);
      d  = data_t'($urandom);
      issue(rd, !rd, a, d, 1'b0);
    end

    waited = 0;
    while (exp_data_q.size() > 0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    assert (exp_data_q.size() == 0) else abort_run("read data still outstanding at end of test");
    repeat (3) @(posedge clk);
    report_and_finish();
  end

endmodule

// File: filelist.f
+incdir+include
src/sram_pkg.sv
src/sram_fsm.sv
src/sram_datapath.sv
src/sram_array.sv
src/sram_subsys_top.sv
tests/sram_sva.sv
tests/sram_tb.sv
